// File: trellis_pkg.sv
`default_nettype none

package trellis_pkg;

   localparam int NUM_STATES = 8;
   localparam int STATE_W    = 3;
   localparam int CODE_W     = 2;

   typedef logic [STATE_W-1:0] state_t;
   typedef logic [CODE_W-1:0]  code_t;

   // Indexed by current state, then input bit
   localparam state_t NEXT_STATE [NUM_STATES][2] = '{
      '{3'd0, 3'd4},
      '{3'd4, 3'd0},
      '{3'd5, 3'd1},
      '{3'd1, 3'd5},
      '{3'd2, 3'd6},
      '{3'd6, 3'd2},
      '{3'd7, 3'd3},
      '{3'd3, 3'd7}
   };

   localparam code_t CODE_OUT [NUM_STATES][2] = '{
      '{2'b00, 2'b11},
      '{2'b00, 2'b11},
      '{2'b10, 2'b01},
      '{2'b10, 2'b01},
      '{2'b10, 2'b01},
      '{2'b10, 2'b01},
      '{2'b00, 2'b11},
      '{2'b00, 2'b11}
   };

   // Two predecessors of each new state
   localparam state_t PRED_0 [NUM_STATES] = '{3'd0, 3'd3, 3'd4, 3'd7, 3'd1, 3'd2, 3'd5, 3'd6};
   localparam state_t PRED_1 [NUM_STATES] = '{3'd1, 3'd2, 3'd5, 3'd6, 3'd0, 3'd3, 3'd4, 3'd7};

   // Pair expected on the branch from each predecessor
   localparam code_t EXP_0 [NUM_STATES] = '{
      2'b00, 2'b10, 2'b10, 2'b00, 2'b00, 2'b10, 2'b10, 2'b00
   };
   localparam code_t EXP_1 [NUM_STATES] = '{
      2'b11, 2'b01, 2'b01, 2'b11, 2'b11, 2'b01, 2'b01, 2'b11
   };

endpackage

`default_nettype wire

// File: metric_pkg.sv
`default_nettype none

package metric_pkg;

   localparam int METRIC_W = 8;

   // Branch metric ranges 0 to 2
   localparam int BM_W = 2;

   typedef logic [METRIC_W-1:0] metric_t;

   // State j sits in bits 8j+7 down to 8j
   typedef metric_t [7:0] metric_arr_t;

   localparam metric_t NORM_MASK = 8'h7f;

   // One flipped code bit per period
   localparam int ERR_PERIOD = 16;
   localparam int ERR_CNT_W  = 4;

endpackage

`default_nettype wire

// File: acs_if.sv
`timescale 1ns/1ps
`default_nettype none

interface acs_if
   import metric_pkg::*;
();

   metric_arr_t pm;
   logic [7:0]  pm_valid;

   // Candidates for the next update
   metric_arr_t new_pm;
   logic [7:0]  new_valid;
   logic [7:0]  new_decision;

   modport acs
   (
      input  pm,
      input  pm_valid,
      output new_pm,
      output new_valid,
      output new_decision
   );

   modport store
   (
      output pm,
      output pm_valid,
      input  new_pm,
      input  new_valid,
      input  new_decision
   );

endinterface

`default_nettype wire

// File: conv_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module conv_encoder
   import trellis_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  enable_i,
   input  logic  data_i,
   output code_t code_o
);

   state_t state;
   state_t next_state;
   code_t  pair;

   // Trellis lookup for the current input bit
   assign next_state = NEXT_STATE[state][data_i];
   assign pair       = CODE_OUT[state][data_i];

   assign code_o = enable_i ? pair : '0;

   // Back to state 0 whenever encoding stops
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state <= '0;
      end
      else if (!enable_i)
      begin
         state <= '0;
      end
      else
      begin
         state <= next_state;
      end
   end

endmodule

`default_nettype wire

// File: error_injector.sv
`timescale 1ns/1ps
`default_nettype none

module error_injector
   import trellis_pkg::*;
   import metric_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  code_t code_i,
   input  logic  enable_i,
   output code_t rx_pair_o,
   output logic  rx_enable_o
);

   logic [ERR_CNT_W-1:0] err_cnt;
   logic                 flip;

   assign flip = (err_cnt == ERR_CNT_W'(ERR_PERIOD - 1));

   // Counter runs regardless of enable
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         err_cnt     <= '0;
         rx_enable_o <= 1'b0;
      end
      else
      begin
         err_cnt     <= err_cnt + ERR_CNT_W'(1);
         rx_enable_o <= enable_i;
      end
   end

   // Bit 1 inverted on the last count of each period
   always_ff @(posedge clk)
   begin
      rx_pair_o <= {code_i[1] ^ flip, code_i[0]};
   end

endmodule

`default_nettype wire

// File: acs_array.sv
`timescale 1ns/1ps
`default_nettype none

module acs_array
   import trellis_pkg::*;
   import metric_pkg::*;
(
   input code_t rx_pair_i,
   acs_if.acs   acs
);

   for (genvar j = 0; j < NUM_STATES; j++)
   begin : g_state
      code_t           diff_0;
      code_t           diff_1;
      logic [BM_W-1:0] bm_0;
      logic [BM_W-1:0] bm_1;
      logic            valid_0;
      logic            valid_1;
      metric_t         cost_0;
      metric_t         cost_1;
      logic            sel;
      logic            valid;

      // Hamming distance to each expected pair
      assign diff_0 = rx_pair_i ^ EXP_0[j];
      assign diff_1 = rx_pair_i ^ EXP_1[j];
      assign bm_0   = {diff_0[1] & diff_0[0], diff_0[1] ^ diff_0[0]};
      assign bm_1   = {diff_1[1] & diff_1[0], diff_1[1] ^ diff_1[0]};

      assign valid_0 = acs.pm_valid[PRED_0[j]];
      assign valid_1 = acs.pm_valid[PRED_1[j]];
      assign cost_0  = acs.pm[PRED_0[j]] + METRIC_W'(bm_0);
      assign cost_1  = acs.pm[PRED_1[j]] + METRIC_W'(bm_1);

      always_comb
      begin
         valid = 1'b1;
         case ({valid_0, valid_1})
            2'b00:
            begin
               valid = 1'b0;
               sel   = 1'b0;
            end
            2'b01:   sel = 1'b1;
            2'b10:   sel = 1'b0;
            // Ties go to path 0
            default: sel = (cost_0 > cost_1);
         endcase
      end

      assign acs.new_valid[j]    = valid;
      assign acs.new_decision[j] = sel;
      assign acs.new_pm[j]       = valid ? (sel ? cost_1 : cost_0) : '0;
   end

endmodule

`default_nettype wire

// File: path_metric_reg.sv
`timescale 1ns/1ps
`default_nettype none

module path_metric_reg
   import metric_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        enable_i,
   acs_if.store        store,
   output logic [7:0]  decision_o,
   output metric_arr_t metric_o,
   output logic [7:0]  metric_valid_o
);

   metric_arr_t pm_q;
   metric_arr_t pm_next;
   logic [7:0]  valid_q;
   logic [7:0]  msb;
   logic        norm;

   always_comb
   begin
      for (int i = 0; i < 8; i++)
      begin
         msb[i] = pm_q[i][METRIC_W-1];
      end
   end

   // All metrics high, so drop the common MSB
   assign norm = &msb;

   always_comb
   begin
      for (int i = 0; i < 8; i++)
      begin
         pm_next[i] = norm ? (store.new_pm[i] & NORM_MASK) : store.new_pm[i];
      end
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         valid_q    <= 8'b0000_0001;
         decision_o <= '0;
         pm_q       <= '0;
      end
      else if (!enable_i)
      begin
         valid_q    <= 8'b0000_0001;
         decision_o <= '0;
         pm_q       <= '0;
      end
      else
      begin
         valid_q    <= store.new_valid;
         decision_o <= store.new_decision;
         pm_q       <= pm_next;
      end
   end

   assign store.pm       = pm_q;
   assign store.pm_valid = valid_q;
   assign metric_o       = pm_q;
   assign metric_valid_o = valid_q;

endmodule

`default_nettype wire

// File: viterbi_tx_rx.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_tx_rx
   import trellis_pkg::*;
   import metric_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           enable_i,
   input  logic                           data_i,
   output logic [CODE_W-1:0]              code_o,
   output logic [NUM_STATES-1:0]          decision_o,
   output logic [NUM_STATES*METRIC_W-1:0] metric_o,
   output logic [NUM_STATES-1:0]          metric_valid_o
);

   code_t rx_pair;
   logic  rx_enable;

   acs_if i_acs ();

   conv_encoder i_encoder
   (
      .clk      (clk),
      .rst      (rst),
      .enable_i (enable_i),
      .data_i   (data_i),
      .code_o   (code_o)
   );

   // Channel model with one cycle of latency
   error_injector i_error
   (
      .clk         (clk),
      .rst         (rst),
      .code_i      (code_o),
      .enable_i    (enable_i),
      .rx_pair_o   (rx_pair),
      .rx_enable_o (rx_enable)
   );

   acs_array i_acs_array
   (
      .rx_pair_i (rx_pair),
      .acs       (i_acs.acs)
   );

   path_metric_reg i_pm_reg
   (
      .clk            (clk),
      .rst            (rst),
      .enable_i       (rx_enable),
      .store          (i_acs.store),
      .decision_o     (decision_o),
      .metric_o       (metric_o),
      .metric_valid_o (metric_valid_o)
   );

endmodule

`default_nettype wire

// File: tb_viterbi_tx_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_viterbi_tx_rx;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;
   localparam int IDLE_CYCLES  = 3;
   localparam int SHORT_RUN    = 20;
   localparam int GAP_CYCLES   = 6;
   localparam int LONG_RUN     = 2600;
   localparam int TAIL_CYCLES  = 4;
   localparam int RUN_CYCLES   = RESET_CYCLES + IDLE_CYCLES + SHORT_RUN + GAP_CYCLES
                                 + LONG_RUN + TAIL_CYCLES + 1;
   localparam int TIMEOUT_CYCLES = RUN_CYCLES + 300;
   localparam logic [31:0] SEED = 32'h9adf_26aa;

   // Encoder trellis indexed by state then input bit
   localparam logic [2:0] ENC_NEXT [8][2] = '{
      '{3'd0, 3'd4}, '{3'd4, 3'd0}, '{3'd5, 3'd1}, '{3'd1, 3'd5},
      '{3'd2, 3'd6}, '{3'd6, 3'd2}, '{3'd7, 3'd3}, '{3'd3, 3'd7}
   };
   localparam logic [1:0] ENC_CODE [8][2] = '{
      '{2'b00, 2'b11}, '{2'b00, 2'b11}, '{2'b10, 2'b01}, '{2'b10, 2'b01},
      '{2'b10, 2'b01}, '{2'b10, 2'b01}, '{2'b00, 2'b11}, '{2'b00, 2'b11}
   };
   localparam logic [2:0] PRED_0 [8] = '{3'd0, 3'd3, 3'd4, 3'd7, 3'd1, 3'd2, 3'd5, 3'd6};
   localparam logic [2:0] PRED_1 [8] = '{3'd1, 3'd2, 3'd5, 3'd6, 3'd0, 3'd3, 3'd4, 3'd7};
   localparam logic [1:0] EXP_0 [8] = '{2'b00, 2'b10, 2'b10, 2'b00, 2'b00, 2'b10, 2'b10, 2'b00};
   localparam logic [1:0] EXP_1 [8] = '{2'b11, 2'b01, 2'b01, 2'b11, 2'b11, 2'b01, 2'b01, 2'b11};

   logic        clk;
   logic        rst;
   logic        enable_i;
   logic        data_i;
   logic [1:0]  code_o;
   logic [7:0]  decision_o;
   logic [63:0] metric_o;
   logic [7:0]  metric_valid_o;

   // Reference model state
   logic [2:0] m_state;
   logic [3:0] m_err_cnt;
   logic [1:0] m_rx_pair;
   logic       m_rx_enable;
   logic [7:0] m_pm [8];
   logic [7:0] m_valid;
   logic [7:0] m_decision;
   int         norm_count  = 0;
   int         cycle_count = 0;

   viterbi_tx_rx i_dut
   (
      .clk            (clk),
      .rst            (rst),
      .enable_i       (enable_i),
      .data_i         (data_i),
      .code_o         (code_o),
      .decision_o     (decision_o),
      .metric_o       (metric_o),
      .metric_valid_o (metric_valid_o)
   );

   initial clk = 1'b0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped after an error");
   endtask

   function automatic logic [1:0] expected_code(logic [2:0] state, logic en, logic d);
      if (!en)
      begin
         return 2'b00;
      end
      return ENC_CODE[state][d];
   endfunction

   function automatic logic [1:0] hamming(logic [1:0] a, logic [1:0] b);
      logic [1:0] x;
      x = a ^ b;
      return {1'b0, x[1]} + {1'b0, x[0]};
   endfunction

   function automatic void reset_reference();
      m_state     = 3'd0;
      m_err_cnt   = 4'd0;
      m_rx_enable = 1'b0;
      m_valid     = 8'b0000_0001;
      m_decision  = 8'd0;
      for (int j = 0; j < 8; j++)
      begin
         m_pm[j] = 8'd0;
      end
   endfunction

   // One clock edge of encoder, channel and metric register
   function automatic void step_reference(logic en, logic d);
      logic [1:0] pair;
      logic [7:0] pm_new [8];
      logic [7:0] valid_new;
      logic [7:0] cost_0;
      logic [7:0] cost_1;
      logic       v0;
      logic       v1;
      logic       sel;
      logic       all_msb;
      pair    = expected_code(m_state, en, d);
      all_msb = 1'b1;
      if (m_rx_enable)
      begin
         for (int j = 0; j < 8; j++)
         begin
            v0     = m_valid[PRED_0[j]];
            v1     = m_valid[PRED_1[j]];
            cost_0 = m_pm[PRED_0[j]] + {6'd0, hamming(m_rx_pair, EXP_0[j])};
            cost_1 = m_pm[PRED_1[j]] + {6'd0, hamming(m_rx_pair, EXP_1[j])};
            sel    = (v0 && v1) ? (cost_0 > cost_1) : v1;
            m_decision[j] = sel;
            pm_new[j] = !(v0 || v1) ? 8'd0 : (sel ? cost_1 : cost_0);
            if (!m_pm[j][7])
            begin
               all_msb = 1'b0;
            end
            valid_new[j] = v0 | v1;
         end
         if (all_msb)
         begin
            norm_count++;
            for (int j = 0; j < 8; j++)
            begin
               pm_new[j][7] = 1'b0;
            end
         end
         m_pm    = pm_new;
         m_valid = valid_new;
      end
      else
      begin
         m_valid    = 8'b0000_0001;
         m_decision = 8'd0;
         for (int j = 0; j < 8; j++)
         begin
            m_pm[j] = 8'd0;
         end
      end
      m_rx_pair   = {pair[1] ^ (m_err_cnt == 4'd15), pair[0]};
      m_rx_enable = en;
      m_err_cnt   = m_err_cnt + 4'd1;
      m_state     = en ? ENC_NEXT[m_state][d] : 3'd0;
   endfunction

   task automatic check_registered();
      assert (metric_valid_o == m_valid)
      else abort_run($sformatf("FAIL at %0t ns: metric_valid_o %b, expected %b",
                               $time, metric_valid_o, m_valid));
      assert (decision_o == m_decision)
      else abort_run($sformatf("FAIL at %0t ns: decision_o %b, expected %b",
                               $time, decision_o, m_decision));
      for (int j = 0; j < 8; j++)
      begin
         assert (metric_o[8*j +: 8] == m_pm[j])
         else abort_run($sformatf("FAIL at %0t ns: metric of state %0d is %0d, expected %0d",
                                  $time, j, metric_o[8*j +: 8], m_pm[j]));
      end
   endtask

   // Model steps on the edge and outputs are compared once settled
   always
   begin
      @(posedge clk);
      if (!rst)
      begin
         reset_reference();
      end
      else
      begin
         step_reference(enable_i, data_i);
      end
      #2;
      check_registered();
      @(negedge clk);
      #1;
      assert (code_o == expected_code(m_state, enable_i, data_i))
      else abort_run($sformatf("FAIL at %0t ns: code_o %b, expected %b", $time, code_o,
                               expected_code(m_state, enable_i, data_i)));
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                             TIMEOUT_CYCLES));
      end
   end

   task automatic drive_cycles(input logic en, input int count);
      for (int i = 0; i < count; i++)
      begin
         @(negedge clk);
         enable_i = en;
         data_i   = 1'($urandom);
      end
   endtask

   initial
   begin
      rst      = 1'b0;
      enable_i = 1'b0;
      data_i   = 1'b0;
      void'($urandom(SEED));
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b1;
      drive_cycles(1'b0, IDLE_CYCLES);
      drive_cycles(1'b1, SHORT_RUN);
      assert (metric_valid_o == 8'hff)
      else abort_run("Path validity did not fill to all states after the first run");
      // Enable dropped mid-run
      drive_cycles(1'b0, GAP_CYCLES);
      assert (metric_valid_o == 8'h01 && metric_o == 64'd0 && decision_o == 8'd0)
      else abort_run("Metric register did not return to its reset values with enable low");
      drive_cycles(1'b1, LONG_RUN);
      drive_cycles(1'b0, TAIL_CYCLES);
      @(negedge clk);
      assert (norm_count > 0)
      else abort_run("Metric normalization never took place during the long run");
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: viterbi_tx_rx.f
trellis_pkg.sv
metric_pkg.sv
acs_if.sv
conv_encoder.sv
error_injector.sv
acs_array.sv
path_metric_reg.sv
viterbi_tx_rx.sv
tb_viterbi_tx_rx.sv

// File: Makefile
TOP = tb_viterbi_tx_rx

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f viterbi_tx_rx.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
